//--- beam_cases.txt
# frame run x y red green blue, colours in hex, cases in raster order per frame
# run is the level for that frame, it decides the move into the next frame
0 1 31 0 F 8 0
0 1 32 0 0 8 F
0 1 700 10 0 0 0
0 1 0 31 F 8 0
0 1 31 31 F 8 0
0 1 0 32 0 8 F
0 1 10 500 0 0 0
1 1 3 10 0 8 F
1 1 4 10 F 8 0
1 1 35 10 F 8 0
1 1 36 10 0 8 F
2 0 7 5 0 8 F
2 0 39 5 F 8 0
3 1 7 5 0 8 F
3 1 39 5 F 8 0
3 1 40 5 0 8 F
4 1 11 20 0 8 F
4 1 43 20 F 8 0
4 1 12 32 0 8 F
5 1 15 0 0 8 F
5 1 47 0 F 8 0
5 1 300 479 0 8 F

//--- build.f
beam_pkg.sv
beam_timing_if.sv
display_timing.sv
square_mover.sv
square_painter.sv
beam_top.sv
tb_beam.sv

//--- run_sim.sh
#!/bin/sh
# build and run the beam testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_beam -f build.f

out=$(./obj_dir/Vtb_beam)
echo "$out"

if echo "$out" | grep -qx "TEST RESULT: PASS"; then
    exit 0
else
    exit 1
fi

//--- tb_beam.sv
/*
 * testbench for the beam test pattern generator
 * replays sample pixels from the case file and checks the whole raster against a model
 */
`timescale 1ns/100ps

module tb_beam import beam_pkg::*; ();

    localparam int max_cases    = 64;
    localparam int frame_cycles = 800 * 525;
    localparam int wait_limit   = 2 * frame_cycles;    // two frames per wait

    logic  clk_pix = 1'b0;
    logic  rst_n;
    logic  run;
    logic  hsync;
    logic  vsync;
    logic  de;
    chan_t red;
    chan_t green;
    chan_t blue;

    // case table
    int    n_cases;
    int    case_frame [max_cases];
    logic  case_run   [max_cases];
    cord_t case_x     [max_cases];
    cord_t case_y     [max_cases];
    chan_t case_r     [max_cases];
    chan_t case_g     [max_cases];
    chan_t case_b     [max_cases];

    // model of the output raster and square
    logic  pix_valid;           // outputs carry a real pixel
    cord_t ox;                  // pixel now on the outputs
    cord_t oy;
    int    frame_idx;
    cord_t mqx;                 // model square corner
    cord_t mqy;

    int    err_reset   = 0;
    int    err_raster  = 0;
    int    err_colour  = 0;
    int    err_case    = 0;
    int    pix_checked = 0;
    int    run_frame;           // frame whose run level is driven
    logic  timed_out;
    logic  file_bad;
    logic  short_run;

    beam_top u_dut (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .run     (run),
        .hsync   (hsync),
        .vsync   (vsync),
        .de      (de),
        .red     (red),
        .green   (green),
        .blue    (blue)
    );

    initial begin
        forever #20 clk_pix = ~clk_pix;     // 25 MHz
    end

    // expected colour of one pixel for a given square corner
    function automatic logic [11:0] pixel_colour(input cord_t x, input cord_t y,
                                                 input cord_t qx, input cord_t qy);
        if (!(x < h_res && y < v_res)) begin
            return 12'h000;                 // blanking is black
        end else if (x >= qx && x < qx + q_size && y >= qy && y < qy + q_size) begin
            return {sq_red, sq_green, sq_blue};
        end else begin
            return {bg_red, bg_green, bg_blue};
        end
    endfunction

    // output position tracker one clock behind the DUT counters
    always @(posedge clk_pix) begin
        if (!rst_n) begin
            pix_valid <= 1'b0;
            ox        <= '0;
            oy        <= '0;
            frame_idx <= 0;
            mqx       <= '0;
            mqy       <= '0;
        end else if (!pix_valid) begin
            pix_valid <= 1'b1;              // pixel 0,0 from now on
        end else if (ox == h_full - 10'd1) begin
            ox <= '0;
            if (oy == v_full - 10'd1) begin
                oy        <= '0;
                frame_idx <= frame_idx + 1;
                if (run) begin              // square moves on the strobe of the old frame
                    if (mqx >= h_full - q_size) begin
                        mqx <= '0;
                        mqy <= (mqy >= v_full - q_size) ? '0 : mqy + q_size;
                    end else begin
                        mqx <= mqx + q_speed;
                    end
                end
            end else begin
                oy <= oy + 10'd1;
            end
        end else begin
            ox <= ox + 10'd1;
        end
    end

    // every output pixel against the model
    always @(negedge clk_pix) begin
        if (rst_n && pix_valid) begin
            pix_checked = pix_checked + 1;
            assert (hsync == !(ox >= h_sync_start && ox < h_sync_end)
                    && vsync == !(oy >= v_sync_start && oy < v_sync_end)
                    && de == (ox < h_res && oy < v_res)
                    && {red, green, blue} == pixel_colour(ox, oy, mqx, mqy)) else begin
                if (err_raster < 20) begin     // keep the log short
                    $display("ERROR %0t ns: pixel %0d,%0d frame %0d hs %b vs %b de %b rgb %h",
                             $time, ox, oy, frame_idx, hsync, vsync, de, {red, green, blue});
                end
                err_raster = err_raster + 1;
            end
        end
    end

    task automatic load_cases();
        int    fd;
        int    got;
        int    fields;
        int    f_t;
        int    r_t;
        int    x_t;
        int    y_t;
        chan_t cr;
        chan_t cg;
        chan_t cb;
        string line_buf;
        n_cases = 0;
        fd = $fopen("beam_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open the case file beam_cases.txt");
            file_bad = 1'b1;
        end else begin
            while (!$feof(fd) && n_cases < max_cases) begin
                got = $fgets(line_buf, fd);
                if (got > 0) begin
                    // comment lines give no fields
                    fields = $sscanf(line_buf, "%d %d %d %d %h %h %h",
                                     f_t, r_t, x_t, y_t, cr, cg, cb);
                    if (fields == 7) begin
                        case_frame[n_cases] = f_t;
                        case_run[n_cases]   = (r_t != 0);
                        case_x[n_cases]     = cord_t'(x_t);
                        case_y[n_cases]     = cord_t'(y_t);
                        case_r[n_cases]     = cr;
                        case_g[n_cases]     = cg;
                        case_b[n_cases]     = cb;
                        n_cases = n_cases + 1;
                    end
                end
            end
            $fclose(fd);
            if (n_cases == 0) begin
                $display("the case file holds no usable cases");
                file_bad = 1'b1;
            end
        end
    endtask

    // wait for a case pixel and drive run at the start of its frame
    task automatic wait_for_pixel(input int idx);
        int   cycles;
        logic found;
        cycles = 0;
        found  = 1'b0;
        while (!found && !timed_out) begin
            if (frame_idx == case_frame[idx] && run_frame != case_frame[idx]) begin
                run       = case_run[idx];
                run_frame = case_frame[idx];
            end
            if (pix_valid && frame_idx == case_frame[idx]
                && ox == case_x[idx] && oy == case_y[idx]) begin
                found = 1'b1;
            end else if (cycles >= wait_limit) begin
                $display("timed out waiting for pixel %0d,%0d of frame %0d",
                         case_x[idx], case_y[idx], case_frame[idx]);
                timed_out = 1'b1;
            end else begin
                @(negedge clk_pix);
                cycles = cycles + 1;
            end
        end
    endtask

    task automatic check_case(input int idx);
        logic [11:0] expect_rgb;
        logic [11:0] model_rgb;
        expect_rgb = {case_r[idx], case_g[idx], case_b[idx]};
        model_rgb  = pixel_colour(case_x[idx], case_y[idx], mqx, mqy);
        assert (model_rgb == expect_rgb) else begin
            $display("ERROR %0t ns: case %0d model gives %h, case file %h",
                     $time, idx, model_rgb, expect_rgb);
            err_case = err_case + 1;
        end
        assert ({red, green, blue} == expect_rgb) else begin
            $display("ERROR %0t ns: case %0d pixel %0d,%0d shows %h, expected %h",
                     $time, idx, case_x[idx], case_y[idx], {red, green, blue}, expect_rgb);
            err_colour = err_colour + 1;
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        run       = 1'b0;
        run_frame = 0;
        timed_out = 1'b0;
        file_bad  = 1'b0;
        short_run = 1'b0;
        load_cases();
        if (!file_bad) begin
            run = case_run[0];              // level for frame 0
        end

        // outputs idle while in reset
        repeat (4) begin
            @(negedge clk_pix);
            assert (hsync && vsync && !de && {red, green, blue} == 12'h000) else begin
                $display("ERROR %0t ns: outputs not idle in reset", $time);
                err_reset = err_reset + 1;
            end
        end
        rst_n = 1'b1;

        if (!file_bad) begin
            for (int i = 0; i < n_cases; i++) begin
                wait_for_pixel(i);
                if (timed_out) begin
                    break;
                end
                check_case(i);
            end
        end

        if (!file_bad && !timed_out) begin
            assert (pix_checked >= frame_cycles) else begin
                $display("the run ended before a full frame was checked");
                short_run = 1'b1;
            end
        end

        $display("errors: reset %0d raster %0d colour %0d case %0d",
                 err_reset, err_raster, err_colour, err_case);
        if (!file_bad && !timed_out && !short_run && err_reset == 0 && err_raster == 0
            && err_colour == 0 && err_case == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- beam_top.sv
/*
 * beam test pattern top
 * timing generator, square mover and painter joined by the timing bundle
 */
`timescale 1ns/100ps

module beam_top import beam_pkg::*; (
    input  logic  clk_pix,      // pixel clock
    input  logic  rst_n,
    input  logic  run,          // animate while high
    output logic  hsync,
    output logic  vsync,
    output logic  de,
    output chan_t red,
    output chan_t green,
    output chan_t blue
);

    beam_timing_if tim ();      // raster bundle

    cord_t qx;                  // square position, mover to painter
    cord_t qy;

    // raster counters and decodes
    display_timing u_timing (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .tim     (tim.src)
    );

    // once-per-frame motion
    square_mover u_mover (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .run     (run),
        .tim     (tim.snk),
        .qx      (qx),
        .qy      (qy)
    );

    // pixel colour and output register
    square_painter u_painter (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .tim     (tim.snk),
        .qx      (qx),
        .qy      (qy),
        .hsync   (hsync),
        .vsync   (vsync),
        .de      (de),
        .red     (red),
        .green   (green),
        .blue    (blue)
    );

endmodule

//--- square_painter.sv
/*
 * square painter and video output stage
 * hit test, colour pick, then one register for colour, syncs and de
 */
`timescale 1ns/100ps

module square_painter import beam_pkg::*; (
    input  logic  clk_pix,
    input  logic  rst_n,
    beam_timing_if.snk tim,
    input  cord_t qx,
    input  cord_t qy,
    output logic  hsync,
    output logic  vsync,
    output logic  de,
    output chan_t red,
    output chan_t green,
    output chan_t blue
);

    logic [cord_w:0] qx_end;    // one past right edge, extra bit for carry
    logic [cord_w:0] qy_end;    // one past bottom edge
    logic            q_hit;     // pixel inside the square
    chan_t           red_d;
    chan_t           green_d;
    chan_t           blue_d;

    assign qx_end = {1'b0, qx} + {1'b0, q_size};
    assign qy_end = {1'b0, qy} + {1'b0, q_size};

    // hit test on the current pixel
    assign q_hit = (tim.sx >= qx) && ({1'b0, tim.sx} < qx_end)
                && (tim.sy >= qy) && ({1'b0, tim.sy} < qy_end);

    // colour pick, black in blanking
    always_comb begin
        if (!tim.de) begin
            red_d   = '0;
            green_d = '0;
            blue_d  = '0;
        end else if (q_hit) begin
            red_d   = sq_red;
            green_d = sq_green;
            blue_d  = sq_blue;
        end else begin
            red_d   = bg_red;
            green_d = bg_green;
            blue_d  = bg_blue;
        end
    end

    // output register, syncs delayed alongside the colour
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            hsync <= 1'b1;      // idle high
            vsync <= 1'b1;
            de    <= 1'b0;
            red   <= '0;
            green <= '0;
            blue  <= '0;
        end else begin
            hsync <= tim.hsync;
            vsync <= tim.vsync;
            de    <= tim.de;
            red   <= red_d;
            green <= green_d;
            blue  <= blue_d;
        end
    end

endmodule

//--- square_mover.sv
/*
 * square position keeper
 * moves the square once per frame in vertical blanking, gated by run
 */
`timescale 1ns/100ps

module square_mover import beam_pkg::*; (
    input  logic  clk_pix,
    input  logic  rst_n,
    input  logic  run,          // low freezes the animation
    beam_timing_if.snk tim,
    output cord_t qx,           // top-left column
    output cord_t qy            // top-left line
);

    cord_t qx_next;
    cord_t qy_next;
    logic  at_right;            // square hit the right of the full line
    logic  at_bottom;           // square past the full frame height
    logic  step;                // update this cycle

    assign at_right  = (qx >= h_full - q_size);   // 768
    assign at_bottom = (qy >= v_full - q_size);   // 493
    assign step      = tim.frame && run;          // run only matters here

    // move and wrap rule
    always_comb begin
        qx_next = qx;
        qy_next = qy;
        if (at_right) begin
            qx_next = '0;                       // back to column 0
            if (at_bottom) begin
                qy_next = '0;                   // wrap to top
            end else begin
                qy_next = qy + q_size;          // down one square
            end
        end else begin
            qx_next = qx + q_speed;
        end
    end

    // position register
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            qx <= '0;
            qy <= '0;
        end else if (step) begin
            qx <= qx_next;
            qy <= qy_next;
        end
    end

endmodule

//--- display_timing.sv
/*
 * display timing generator for 640x480 on an 800x525 raster
 * counts columns and lines and decodes syncs, data enable and frame strobe
 */
`timescale 1ns/100ps

module display_timing import beam_pkg::*; (
    input  logic clk_pix,
    input  logic rst_n,
    beam_timing_if.src tim
);

    cord_t sx_q;            // column counter
    cord_t sy_q;            // line counter
    logic  line_end;        // last column of a line
    logic  frame_end;       // last line of a frame

    assign line_end  = (sx_q == h_full - 10'd1);
    assign frame_end = (sy_q == v_full - 10'd1);

    // column counter, wraps every line
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            sx_q <= '0;
        end else if (line_end) begin
            sx_q <= '0;
        end else begin
            sx_q <= sx_q + 10'd1;
        end
    end

    // line counter, steps once per line
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            sy_q <= '0;
        end else if (line_end) begin
            if (frame_end) begin
                sy_q <= '0;             // back to top
            end else begin
                sy_q <= sy_q + 10'd1;
            end
        end
    end

    // decodes of the current position, same cycle
    always_comb begin
        tim.sx = sx_q;
        tim.sy = sy_q;

        // sync pulses low inside their window
        tim.hsync = ~((sx_q >= h_sync_start) && (sx_q < h_sync_end));
        tim.vsync = ~((sy_q >= v_sync_start) && (sy_q < v_sync_end));

        // visible area only
        tim.de = (sx_q < h_res) && (sy_q < v_res);

        /* one strobe per frame, first pixel of the first blanking line,
           so anything updated here settles well before line 0 */
        tim.frame = (sy_q == v_res) && (sx_q == '0);
    end

endmodule

//--- beam_timing_if.sv
/*
 * raster timing bundle
 * coordinates, syncs, data enable and frame strobe from the timing block
 */
`timescale 1ns/100ps

interface beam_timing_if import beam_pkg::*; ();

    cord_t sx;      // current column
    cord_t sy;      // current line
    logic  hsync;   // active low
    logic  vsync;   // active low
    logic  de;      // visible area
    logic  frame;   // one cycle, start of vertical blanking

    // timing generator drives everything
    modport src (
        output sx, sy, hsync, vsync, de, frame
    );

    // consumers only look
    modport snk (
        input sx, sy, hsync, vsync, de, frame
    );

endinterface

//--- beam_pkg.sv
/*
 * beam test pattern package
 * raster sizes, square geometry, colours and shared types
 */
package beam_pkg;

    // coordinate width and type
    localparam int cord_w = 10;             // enough for 800 and 525
    typedef logic [cord_w-1:0] cord_t;      // screen coordinate

    // visible area
    localparam cord_t h_res = 10'd640;
    localparam cord_t v_res = 10'd480;

    // full raster incl blanking
    localparam cord_t h_full = 10'd800;     // pixels per line
    localparam cord_t v_full = 10'd525;     // lines per frame

    // sync windows, end is exclusive, both syncs active low
    localparam cord_t h_sync_start = 10'd656;
    localparam cord_t h_sync_end   = 10'd752;
    localparam cord_t v_sync_start = 10'd490;
    localparam cord_t v_sync_end   = 10'd492;

    // moving square
    localparam cord_t q_size  = 10'd32;     // edge in pixels
    localparam cord_t q_speed = 10'd4;      // pixels per frame

    // colour channel
    localparam int chan_w = 4;
    typedef logic [chan_w-1:0] chan_t;

    // square is orange
    localparam chan_t sq_red   = 4'hF;
    localparam chan_t sq_green = 4'h8;
    localparam chan_t sq_blue  = 4'h0;

    // background is sky blue
    localparam chan_t bg_red   = 4'h0;
    localparam chan_t bg_green = 4'h8;
    localparam chan_t bg_blue  = 4'hF;

endpackage
